/* verilog/recorder_pkg.sv */
`default_nettype none

package recorder_pkg;

	// Transport state encoding
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		PLAY       = 3'd1,
		REC        = 3'd2,
		REC_PAUSE  = 3'd3,
		PLAY_PAUSE = 3'd4
	} transport_state_t;

	typedef logic [3:0] speed_t;

	// Fast ratios x1 to x8
	localparam speed_t SPEED_X1 = 4'd1;
	localparam speed_t SPEED_X2 = 4'd2;
	localparam speed_t SPEED_X3 = 4'd3;
	localparam speed_t SPEED_X4 = 4'd4;
	localparam speed_t SPEED_X5 = 4'd5;
	localparam speed_t SPEED_X6 = 4'd6;
	localparam speed_t SPEED_X7 = 4'd7;
	localparam speed_t SPEED_X8 = 4'd8;
	// Slow ratios 1/2 to 1/8 follow right after x8
	localparam speed_t SPEED_DIV2 = 4'd9;
	localparam speed_t SPEED_DIV3 = 4'd10;
	localparam speed_t SPEED_DIV4 = 4'd11;
	localparam speed_t SPEED_DIV5 = 4'd12;
	localparam speed_t SPEED_DIV6 = 4'd13;
	localparam speed_t SPEED_DIV7 = 4'd14;
	localparam speed_t SPEED_DIV8 = 4'd15;

	localparam int SAMPLE_W = 16;
	localparam int BIT_CNT_W = 5;           // Counts 0 to SAMPLE_W
	localparam int SECONDS_W = 7;
	localparam int DEFAULT_ADDR_W = 20;
	localparam int DEFAULT_FRAME_RATE = 15577; // Codec frames per second at x1

endpackage

`default_nettype wire

/* verilog/transport_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module transport_fsm (
	input wire CLOCK_50,
	input wire reset,
	input wire play_key,
	input wire rec_key,
	input wire stop_key,
	input wire take_end,
	output recorder_pkg::transport_state_t state
);
	import recorder_pkg::*;

	logic play_only;
	logic rec_only;
	logic stop_only;
	transport_state_t state_next;

	// A key counts only when it is alone
	assign play_only = play_key & ~rec_key & ~stop_key;
	assign rec_only = rec_key & ~play_key & ~stop_key;
	assign stop_only = stop_key & ~play_key & ~rec_key;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (play_only)
					state_next = PLAY;
				else if (rec_only)
					state_next = REC;
			end
			PLAY: begin
				if (stop_only || take_end)
					state_next = IDLE;
				else if (play_only)
					state_next = PLAY_PAUSE;
			end
			REC: begin
				if (stop_only || take_end)
					state_next = IDLE;
				else if (rec_only)
					state_next = REC_PAUSE;
			end
			PLAY_PAUSE: begin
				if (stop_only)
					state_next = IDLE;
				else if (play_only)
					state_next = PLAY;  // Resume
			end
			REC_PAUSE: begin
				if (stop_only)
					state_next = IDLE;
				else if (rec_only)
					state_next = REC;
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

/* verilog/speed_selector.sv */
`timescale 1ns/1ps
`default_nettype none

module speed_selector (
	input wire CLOCK_50,
	input wire reset,
	input wire speed_enable,
	input wire speed_step,
	input wire speed_slow,
	output recorder_pkg::speed_t speed
);
	import recorder_pkg::*;

	speed_t faster;
	speed_t slower;

	// Next code toward faster playback
	always_comb begin
		case (speed)
			SPEED_X1, SPEED_X2, SPEED_X3, SPEED_X4,
			SPEED_X5, SPEED_X6, SPEED_X7: faster = speed + 1'b1;
			SPEED_DIV3, SPEED_DIV4, SPEED_DIV5,
			SPEED_DIV6, SPEED_DIV7, SPEED_DIV8: faster = speed - 1'b1; // 1/n to 1/(n-1)
			default: faster = SPEED_X1;  // x8 wraps, 1/2 back to x1
		endcase
	end

	// Next code toward slower playback
	always_comb begin
		case (speed)
			SPEED_X1: slower = SPEED_DIV2;
			SPEED_X2, SPEED_X3, SPEED_X4, SPEED_X5,
			SPEED_X6, SPEED_X7, SPEED_X8: slower = speed - 1'b1;
			SPEED_DIV2, SPEED_DIV3, SPEED_DIV4,
			SPEED_DIV5, SPEED_DIV6, SPEED_DIV7: slower = speed + 1'b1;
			default: slower = SPEED_X1;  // 1/8 wraps
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			speed <= SPEED_X1;
		end else if (!speed_enable) begin
			speed <= SPEED_X1;
		end else if (speed_step) begin
			speed <= speed_slow ? slower : faster;
		end
	end

endmodule

`default_nettype wire

/* verilog/codec_frame_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module codec_frame_sync (
	input wire CLOCK_50,
	input wire reset,
	input wire aud_bclk,
	input wire aud_lrck,
	input wire aud_adcdat,
	output logic bit_strobe,
	output logic frame_start,
	output logic adc_bit
);

	logic [1:0] bclk_sync;
	logic [1:0] lrck_sync;
	logic [1:0] adc_sync;
	logic bclk_prev;
	logic lrck_prev;

	// Two sync flops, then the edge stage
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			bclk_sync <= 2'b00;
			lrck_sync <= 2'b00;
			bclk_prev <= 1'b0;
			lrck_prev <= 1'b0;
			bit_strobe <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], aud_bclk};
			lrck_sync <= {lrck_sync[0], aud_lrck};
			bclk_prev <= bclk_sync[1];
			lrck_prev <= lrck_sync[1];
			bit_strobe <= bclk_sync[1] & ~bclk_prev & lrck_sync[1];  // Left half only
			frame_start <= lrck_sync[1] & ~lrck_prev;
		end
	end

	// Data bit stays aligned with bit_strobe
	always_ff @(posedge CLOCK_50) begin
		adc_sync <= {adc_sync[0], aud_adcdat};
		adc_bit <= adc_sync[1];
	end

endmodule

`default_nettype wire

/* verilog/sample_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_shifter (
	input wire CLOCK_50,
	input wire reset,
	input wire recorder_pkg::transport_state_t state,
	input wire bit_strobe,
	input wire frame_start,
	input wire adc_bit,
	input wire [recorder_pkg::SAMPLE_W-1:0] sram_rdata,
	output logic [recorder_pkg::SAMPLE_W-1:0] sample_word,
	output logic word_done,
	output logic aud_dacdat
);
	import recorder_pkg::*;

	logic [BIT_CNT_W-1:0] bit_cnt;
	logic active;
	logic take_bit;

	assign active = (state == REC) || (state == PLAY);
	// Counter parks at SAMPLE_W, so later bits and partial frames are ignored
	assign take_bit = bit_strobe && (bit_cnt < SAMPLE_W);

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			bit_cnt <= BIT_CNT_W'(SAMPLE_W);
			word_done <= 1'b0;
			aud_dacdat <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (!active) begin
				bit_cnt <= BIT_CNT_W'(SAMPLE_W);  // Wait for a fresh frame
			end else if (frame_start) begin
				bit_cnt <= '0;
			end else if (take_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				word_done <= (bit_cnt == SAMPLE_W - 1);
			end

			if (state != PLAY)
				aud_dacdat <= 1'b0;
			else if (frame_start)
				aud_dacdat <= sram_rdata[SAMPLE_W-1];  // MSB ready for the first rise
			else if (take_bit)
				aud_dacdat <= sample_word[SAMPLE_W-2];
		end
	end

	// Shared shift register, ADC in from the right or DAC out at the top
	always_ff @(posedge CLOCK_50) begin
		if ((state == PLAY) && frame_start) begin
			sample_word <= sram_rdata;
		end else if (take_bit) begin
			if (state == REC)
				sample_word <= {sample_word[SAMPLE_W-2:0], adc_bit};
			else
				sample_word <= {sample_word[SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* verilog/sram_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_sequencer #(
	parameter int addr_w = recorder_pkg::DEFAULT_ADDR_W
) (
	input wire CLOCK_50,
	input wire reset,
	input wire recorder_pkg::transport_state_t state,
	input wire word_done,
	input wire [recorder_pkg::SAMPLE_W-1:0] sample_word,
	output logic [addr_w-1:0] sram_addr,
	output logic [recorder_pkg::SAMPLE_W-1:0] sram_wdata,
	output logic sram_we_n,
	output logic take_end
);
	import recorder_pkg::*;

	logic [addr_w:0] take_len;  // One extra bit for a full memory

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			sram_addr <= '0;
			sram_we_n <= 1'b1;
			take_len <= '0;
			take_end <= 1'b0;
		end else begin
			sram_we_n <= 1'b1;
			take_end <= 1'b0;

			// Write cycle just ended, step past it
			if (!sram_we_n) begin
				sram_addr <= sram_addr + 1'b1;
				take_len <= {1'b0, sram_addr} + 1'b1;
				take_end <= &sram_addr;  // Top address written
			end

			if (word_done && (state == REC))
				sram_we_n <= 1'b0;

			if (word_done && (state == PLAY)) begin
				sram_addr <= sram_addr + 1'b1;
				take_end <= (({1'b0, sram_addr} + 1'b1) == take_len);  // Last recorded word
			end

			if (state == IDLE)
				sram_addr <= '0;
		end
	end

	// Data held from word_done through the write cycle
	always_ff @(posedge CLOCK_50) begin
		if (word_done && (state == REC))
			sram_wdata <= sample_word;
	end

endmodule

`default_nettype wire

/* verilog/elapsed_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module elapsed_timer #(
	parameter int frame_rate = recorder_pkg::DEFAULT_FRAME_RATE
) (
	input wire CLOCK_50,
	input wire reset,
	input wire recorder_pkg::transport_state_t state,
	input wire frame_start,
	output logic [recorder_pkg::SECONDS_W-1:0] seconds
);
	import recorder_pkg::*;

	logic [$clog2(frame_rate+1)-1:0] frame_cnt;

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			frame_cnt <= '0;
			seconds <= '0;
		end else if (state == IDLE) begin
			frame_cnt <= '0;
			seconds <= '0;
		end else if (((state == PLAY) || (state == REC)) && frame_start) begin
			if (frame_cnt == frame_rate - 1) begin
				frame_cnt <= '0;
				seconds <= seconds + 1'b1;  // Wraps at 128
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/audio_recorder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_recorder_top #(
	parameter int addr_w = recorder_pkg::DEFAULT_ADDR_W,
	parameter int frame_rate = recorder_pkg::DEFAULT_FRAME_RATE
) (
	input wire CLOCK_50,
	input wire reset,
	input wire play_key,
	input wire rec_key,
	input wire stop_key,
	input wire speed_enable,
	input wire speed_step,
	input wire speed_slow,
	input wire aud_bclk,
	input wire aud_lrck,
	input wire aud_adcdat,
	input wire [recorder_pkg::SAMPLE_W-1:0] sram_rdata,
	output logic aud_dacdat,
	output logic [addr_w-1:0] sram_addr,
	output logic [recorder_pkg::SAMPLE_W-1:0] sram_wdata,
	output logic sram_we_n,
	output recorder_pkg::transport_state_t state,
	output recorder_pkg::speed_t speed,
	output logic [recorder_pkg::SECONDS_W-1:0] seconds
);
	import recorder_pkg::*;

	logic take_end;
	logic bit_strobe;  // Left half only
	logic frame_start;
	logic adc_bit;
	logic word_done;
	logic [SAMPLE_W-1:0] sample_word;

	transport_fsm u_transport (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.play_key(play_key), .rec_key(rec_key), .stop_key(stop_key),
		.take_end(take_end), .state(state)
	);

	// Status only, no internal rate change
	speed_selector u_speed (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.speed_enable(speed_enable), .speed_step(speed_step),
		.speed_slow(speed_slow), .speed(speed)
	);

	codec_frame_sync u_frame_sync (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.aud_bclk(aud_bclk), .aud_lrck(aud_lrck), .aud_adcdat(aud_adcdat),
		.bit_strobe(bit_strobe), .frame_start(frame_start), .adc_bit(adc_bit)
	);

	sample_shifter u_shifter (
		.CLOCK_50(CLOCK_50), .reset(reset), .state(state),
		.bit_strobe(bit_strobe), .frame_start(frame_start), .adc_bit(adc_bit),
		.sram_rdata(sram_rdata), .sample_word(sample_word),
		.word_done(word_done), .aud_dacdat(aud_dacdat)
	);

	sram_sequencer #(.addr_w(addr_w)) u_sequencer (
		.CLOCK_50(CLOCK_50), .reset(reset), .state(state),
		.word_done(word_done), .sample_word(sample_word),
		.sram_addr(sram_addr), .sram_wdata(sram_wdata),
		.sram_we_n(sram_we_n), .take_end(take_end)
	);

	elapsed_timer #(.frame_rate(frame_rate)) u_timer (
		.CLOCK_50(CLOCK_50), .reset(reset), .state(state),
		.frame_start(frame_start), .seconds(seconds)
	);

endmodule

`default_nettype wire

/* tests/tb_audio_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_recorder;
	import recorder_pkg::*;

	localparam int ADDR_W = 4;
	localparam int FRAME_CYCLES = 256;
	// Reset and transport 2, record 7, playback 7, speed 1, full take 21
	localparam int TEST_FRAMES = 2 + 7 + 7 + 1 + 21;
	localparam int CYCLE_LIMIT = TEST_FRAMES * FRAME_CYCLES * 3 / 2;

	logic CLOCK_50;
	logic reset;
	logic play_key, rec_key, stop_key;
	logic speed_enable, speed_step, speed_slow;
	logic aud_bclk, aud_lrck, aud_adcdat;
	logic [SAMPLE_W-1:0] sram_rdata;
	logic aud_dacdat;
	logic [ADDR_W-1:0] sram_addr;
	logic [SAMPLE_W-1:0] sram_wdata;
	logic sram_we_n;
	transport_state_t state;
	speed_t speed;
	logic [SECONDS_W-1:0] seconds;

	logic [7:0] frame_cyc;        // Position in the 256 cycle codec frame
	logic [31:0] lcg_state;
	logic [SAMPLE_W-1:0] adc_word;
	logic [SAMPLE_W-1:0] mem [0:15];
	logic [SAMPLE_W-1:0] take_words [0:15];
	int error_count;
	int cycle_count;

	audio_recorder_top #(.addr_w(ADDR_W), .frame_rate(4)) dut0 (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.play_key(play_key), .rec_key(rec_key), .stop_key(stop_key),
		.speed_enable(speed_enable), .speed_step(speed_step), .speed_slow(speed_slow),
		.aud_bclk(aud_bclk), .aud_lrck(aud_lrck), .aud_adcdat(aud_adcdat),
		.sram_rdata(sram_rdata), .aud_dacdat(aud_dacdat), .sram_addr(sram_addr),
		.sram_wdata(sram_wdata), .sram_we_n(sram_we_n), .state(state),
		.speed(speed), .seconds(seconds)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Codec: bclk is CLOCK_50/8, lrck high for the first 16 bit clocks
	always @(negedge CLOCK_50) begin
		frame_cyc <= frame_cyc + 8'd1;
		if (frame_cyc == 8'd255)
			lcg_state <= lcg_next(lcg_state);  // New sample each frame
	end
	assign adc_word = lcg_state[31:16];
	assign aud_bclk = frame_cyc[2];
	assign aud_lrck = ~frame_cyc[7];
	assign aud_adcdat = ~frame_cyc[7] & adc_word[4'd15 - frame_cyc[6:3]];  // MSB first

	// Asynchronous SRAM
	assign sram_rdata = mem[sram_addr];
	always @(posedge CLOCK_50) begin
		if (!sram_we_n)
			mem[sram_addr] <= sram_wdata;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Returns on the falling edge where the frame position reads c
	task automatic wait_cyc(input logic [7:0] c);
		@(negedge CLOCK_50);
		while (frame_cyc != c)
			@(negedge CLOCK_50);
	endtask

	task automatic pulse_key(input logic play, input logic rec, input logic stop);
		play_key = play;
		rec_key = rec;
		stop_key = stop;
		@(negedge CLOCK_50);
		play_key = 1'b0;
		rec_key = 1'b0;
		stop_key = 1'b0;
	endtask

	task automatic press_and_expect(input logic play, input logic rec, input logic stop,
			input transport_state_t expected);
		pulse_key(play, rec, stop);
		check_value("state", expected, state);
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (state != IDLE && n < limit) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (state != IDLE) begin
			error_count++;
			$display("State did not return to IDLE within %0d cycles at %0t", limit, $time);
		end
	endtask

	// One word per frame, starting at a frame boundary
	task automatic record_words(input int first, input int count);
		int i;
		for (i = first; i < first + count; i++) begin
			wait_cyc(8'd8);
			check_value("state", REC, state);
			take_words[i] = adc_word;
			wait_cyc(8'd255);
		end
	endtask

	task automatic check_memory(input int count);
		int i;
		for (i = 0; i < count; i++)
			check_value($sformatf("mem[%0d]", i), take_words[i], mem[i]);
	endtask

	task automatic step_speed(input logic slow, input speed_t expected);
		speed_slow = slow;
		speed_step = 1'b1;
		@(negedge CLOCK_50);
		speed_step = 1'b0;
		check_value("speed", expected, speed);
		@(negedge CLOCK_50);
		check_value("speed", expected, speed);  // Held without a step
	endtask

	task automatic test_reset();
		check_value("state", IDLE, state);
		check_value("sram_we_n", 1'b1, sram_we_n);
		check_value("aud_dacdat", 1'b0, aud_dacdat);
		check_value("speed", SPEED_X1, speed);
		check_value("seconds", 0, seconds);
	endtask

	task automatic test_transport();
		press_and_expect(1'b0, 1'b1, 1'b0, REC);
		press_and_expect(1'b0, 1'b1, 1'b0, REC_PAUSE);
		press_and_expect(1'b0, 1'b1, 1'b0, REC);  // Resume
		press_and_expect(1'b0, 1'b0, 1'b1, IDLE);
		press_and_expect(1'b0, 1'b1, 1'b0, REC);
		press_and_expect(1'b0, 1'b1, 1'b0, REC_PAUSE);
		press_and_expect(1'b0, 1'b0, 1'b1, IDLE);
		press_and_expect(1'b1, 1'b0, 1'b0, PLAY);
		press_and_expect(1'b1, 1'b0, 1'b0, PLAY_PAUSE);
		press_and_expect(1'b1, 1'b0, 1'b0, PLAY);
		press_and_expect(1'b0, 1'b0, 1'b1, IDLE);
		press_and_expect(1'b1, 1'b1, 1'b0, IDLE);  // Two keys at once
	endtask

	task automatic test_record();
		wait_cyc(8'd255);
		pulse_key(1'b0, 1'b1, 1'b0);
		record_words(0, 6);
		check_value("sram_addr", 6, sram_addr);
		press_and_expect(1'b0, 1'b0, 1'b1, IDLE);
		check_memory(6);
	endtask

	task automatic test_playback();
		logic [SAMPLE_W-1:0] word;
		int w;
		int b;
		wait_cyc(8'd255);
		pulse_key(1'b1, 1'b0, 1'b0);
		for (w = 0; w < 6; w++) begin
			check_value("state", PLAY, state);
			for (b = 0; b < SAMPLE_W; b++) begin
				wait_cyc(8'(8 * b + 4));  // Just after the bclk rise
				word[SAMPLE_W-1-b] = aud_dacdat;
			end
			check_value($sformatf("dac word %0d", w), take_words[w], word);
			if (w < 5)
				wait_cyc(8'd255);
		end
		wait_idle(FRAME_CYCLES);
		@(negedge CLOCK_50);
		check_value("aud_dacdat", 1'b0, aud_dacdat);
	endtask

	task automatic test_speed();
		int n;
		speed_enable = 1'b1;
		@(negedge CLOCK_50);
		for (n = 2; n <= 8; n++)
			step_speed(1'b0, speed_t'(n));
		step_speed(1'b0, SPEED_X1);  // x8 wraps
		for (n = 9; n <= 15; n++)
			step_speed(1'b1, speed_t'(n));
		step_speed(1'b1, SPEED_X1);  // 1/8 wraps
		for (n = 9; n <= 15; n++)
			step_speed(1'b1, speed_t'(n));
		for (n = 14; n >= 9; n--)
			step_speed(1'b0, speed_t'(n));
		step_speed(1'b0, SPEED_X1);
		for (n = 2; n <= 8; n++)
			step_speed(1'b0, speed_t'(n));
		for (n = 7; n >= 1; n--)
			step_speed(1'b1, speed_t'(n));
		step_speed(1'b0, SPEED_X2);
		speed_enable = 1'b0;
		@(negedge CLOCK_50);
		check_value("speed", SPEED_X1, speed);
		step_speed(1'b0, SPEED_X1);  // Ignored while disabled
	endtask

	task automatic test_timer_full();
		wait_cyc(8'd255);
		pulse_key(1'b0, 1'b1, 1'b0);
		record_words(0, 8);
		check_value("seconds", 2, seconds);
		press_and_expect(1'b0, 1'b1, 1'b0, REC_PAUSE);
		wait_cyc(8'd255);
		wait_cyc(8'd255);
		check_value("seconds", 2, seconds);
		check_value("sram_addr", 8, sram_addr);
		pulse_key(1'b0, 1'b1, 1'b0);
		record_words(8, 8);
		wait_idle(FRAME_CYCLES);
		@(negedge CLOCK_50);
		check_value("seconds", 0, seconds);
		check_memory(16);
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLOCK_50);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d errors", cycle_count, error_count);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		int i;
		error_count = 0;
		frame_cyc = 8'd0;
		lcg_state = 32'h919a_8333;
		play_key = 1'b0;
		rec_key = 1'b0;
		stop_key = 1'b0;
		speed_enable = 1'b0;
		speed_step = 1'b0;
		speed_slow = 1'b0;
		for (i = 0; i < 16; i++)
			mem[i] = (16'h1111 * 16'(i)) ^ 16'h5a5a;
		reset = 1'b1;
		repeat (4) @(negedge CLOCK_50);
		reset = 1'b0;
		@(negedge CLOCK_50);

		test_reset();
		test_transport();
		test_record();
		test_playback();
		test_speed();
		test_timer_full();

		$display("Run finished with %0d errors", error_count);
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
verilog/recorder_pkg.sv
verilog/transport_fsm.sv
verilog/speed_selector.sv
verilog/codec_frame_sync.sv
verilog/sample_shifter.sv
verilog/sram_sequencer.sv
verilog/elapsed_timer.sv
verilog/audio_recorder_top.sv
tests/tb_audio_recorder.sv
